// ==== Bender.yml ====
package:
  name: line_table_accelerator

sources:
  - files:
      - hdl/line_table_pkg.sv
      - hdl/line_cmd_if.sv
      - hdl/host_register_port.sv
      - hdl/code_buffer.sv
      - hdl/operand_decoder.sv
      - hdl/line_program_control.sv
      - hdl/line_state_regs.sv
      - hdl/line_table_accelerator.sv
  - target: test
    files:
      - testbench/line_table_props.sv
      - testbench/line_table_tb.sv

// ==== hdl/code_buffer.sv ====
// Holds the latest PROGRAM_CODE word and hands its bytes to the parser one at a time
module code_buffer
    import line_table_pkg::*;
(
    input  logic        clk,
    input  logic        reset_this_cycle,
    input  logic        write_header,
    input  logic        write_code,
    input  rw_size_e    write_size,
    input  logic [31:0] data_in,
    input  logic        take_byte,
    output logic [7:0]  current_byte,
    output logic        byte_valid
);
    logic [31:0] code_word;
    rw_size_e    code_size;
    logic [2:0]  byte_ptr;
    logic        ptr_in_word;

    // Bytes above the written size are stored as zero
    always_ff @(posedge clk) begin
        if (write_code) begin
            case (write_size)
                RW_8_BIT:  code_word <= {24'h0, data_in[7:0]};
                RW_16_BIT: code_word <= {16'h0, data_in[15:0]};
                default:   code_word <= data_in;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_this_cycle || write_header) begin
            code_size <= RW_NONE;
            byte_ptr  <= 3'h0;
        end else if (write_code) begin
            code_size <= write_size;
            byte_ptr  <= 3'h0;
        end else if (take_byte) begin
            byte_ptr <= byte_ptr + 3'h1;
        end
    end

    // The pointer runs one past the last byte so that an empty word can be told apart
    always_comb begin
        case (byte_ptr)
            3'h0:    current_byte = code_word[7:0];
            3'h1:    current_byte = code_word[15:8];
            3'h2:    current_byte = code_word[23:16];
            3'h3:    current_byte = code_word[31:24];
            default: current_byte = 8'h0;
        endcase
        case (byte_ptr)
            3'h0:      ptr_in_word = code_size != RW_NONE;
            3'h1:      ptr_in_word = code_size == RW_16_BIT || code_size == RW_32_BIT;
            3'h2, 3'h3: ptr_in_word = code_size == RW_32_BIT;
            default:   ptr_in_word = 1'b0;
        endcase
    end

    // A word being replaced this cycle offers no byte
    assign byte_valid = ptr_in_word && !write_code;

endmodule

// ==== hdl/host_register_port.sv ====
// Turns host bus writes into one-cycle strobes and returns the addressed register on reads
module host_register_port
    import line_table_pkg::*;
(
    input  logic        reset_this_cycle,
    input  logic [5:0]  address,
    input  rw_size_e    data_write_n,
    input  rw_size_e    data_read_n,
    input  logic [31:0] row_address,
    input  logic [31:0] row_file,
    input  logic [31:0] row_line_col_flags,
    input  logic [31:0] header_word,
    input  logic        status,
    output logic [31:0] data_out,
    output logic        data_ready,
    output logic        write_header,
    output logic        write_code,
    output logic        write_status
);
    logic        write_this_cycle;
    logic [31:0] selected;

    assign write_this_cycle = !reset_this_cycle && data_write_n != RW_NONE;
    assign write_header     = write_this_cycle && address == PROGRAM_HEADER;
    assign write_code       = write_this_cycle && address == PROGRAM_CODE;
    assign write_status     = write_this_cycle && address == STATUS;

    always_comb begin
        case (address)
            PROGRAM_HEADER:    selected = header_word;
            AM_ADDRESS:        selected = row_address;
            AM_FILE:           selected = row_file;
            AM_LINE_COL_FLAGS: selected = row_line_col_flags;
            STATUS:            selected = {31'h0, status};
            default:           selected = 32'h0;
        endcase
    end

    // Bytes outside the requested read size read as zero
    assign data_out[7:0]   = (data_read_n != RW_NONE) ? selected[7:0] : 8'h0;
    assign data_out[15:8]  = (data_read_n == RW_16_BIT || data_read_n == RW_32_BIT) ?
                             selected[15:8] : 8'h0;
    assign data_out[31:16] = (data_read_n == RW_32_BIT) ? selected[31:16] : 16'h0;

    // The register port never stalls the host
    assign data_ready = 1'b1;

endmodule

// ==== hdl/line_cmd_if.sv ====
// Command bundle from the opcode FSM to the abstract machine registers
interface line_cmd_if
    import line_table_pkg::*;
();
    logic   exec;
    logic   negate_stmt;
    logic   set_basic_block;
    logic   set_end_sequence;
    logic   clear_row_flags;
    logic   end_sequence_reset;
    instr_e instr;

    modport ctrl (
        output exec, instr, negate_stmt, set_basic_block, set_end_sequence,
               clear_row_flags, end_sequence_reset
    );

    modport regs (
        input exec, instr, negate_stmt, set_basic_block, set_end_sequence,
              clear_row_flags, end_sequence_reset
    );
endinterface

// ==== hdl/line_program_control.sv ====
// Opcode decode FSM of the line program parser, owning the row status and the host interrupt
module line_program_control
    import line_table_pkg::*;
(
    input  logic       clk,
    input  logic       reset_this_cycle,
    input  logic       write_header,
    input  logic       write_status,
    input  logic [7:0] current_byte,
    input  logic       byte_valid,
    input  logic       last_byte,
    output logic       take_byte,
    output logic       start_leb,
    output logic       is_signed,
    line_cmd_if.ctrl   cmd,
    output logic       status,
    output logic       user_interrupt
);
    typedef enum logic [2:0] {
        ST_READY,
        ST_EXTENDED,
        ST_PAUSE_COPY,
        ST_PAUSE_END,
        ST_PARSE_LEB,
        ST_EXEC
    } state_e;

    state_e state;
    instr_e instr;
    instr_e opcode_instr;
    logic   leb_first;
    logic   row_pending;
    logic   paused;
    logic   take_opcode;
    logic   take_sub_opcode;
    logic   emit_row;

    assign paused          = state == ST_PAUSE_COPY || state == ST_PAUSE_END;
    assign take_byte       = byte_valid && !write_header && !write_status && !paused &&
                             state != ST_EXEC;
    assign take_opcode     = take_byte && state == ST_READY;
    assign take_sub_opcode = take_byte && state == ST_EXTENDED;
    assign emit_row        = (take_opcode && current_byte == DW_LNS_COPY) ||
                             (take_sub_opcode && current_byte == DW_LNE_END_SEQUENCE);
    assign start_leb       = state == ST_PARSE_LEB && leb_first;
    assign is_signed       = instr == INSTR_ADVANCE_LINE;

    // Opcodes that need an operand, the escape byte counting as one for its length field
    always_comb begin
        case (current_byte)
            DW_LNS_ADVANCE_PC:   opcode_instr = INSTR_ADVANCE_PC;
            DW_LNS_ADVANCE_LINE: opcode_instr = INSTR_ADVANCE_LINE;
            DW_LNS_SET_FILE:     opcode_instr = INSTR_SET_FILE;
            DW_LNS_SET_COLUMN:   opcode_instr = INSTR_SET_COLUMN;
            EXT_OPCODE_ESCAPE:   opcode_instr = INSTR_EXTENDED;
            default:             opcode_instr = INSTR_NOP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_this_cycle || write_header) begin
            state     <= ST_READY;
            instr     <= INSTR_NOP;
            leb_first <= 1'b0;
        end else begin
            case (state)
                ST_READY: begin
                    if (take_byte && current_byte == DW_LNS_COPY) begin
                        state <= ST_PAUSE_COPY;
                    end else if (take_byte && opcode_instr != INSTR_NOP) begin
                        state     <= ST_PARSE_LEB;
                        instr     <= opcode_instr;
                        leb_first <= 1'b1;
                    end
                end
                ST_EXTENDED: begin
                    // Unknown sub-opcodes are dropped and parsing carries on
                    if (take_byte && current_byte == DW_LNE_END_SEQUENCE) begin
                        state <= ST_PAUSE_END;
                    end else if (take_byte) begin
                        state <= ST_READY;
                    end
                end
                ST_PARSE_LEB: begin
                    if (take_byte) begin
                        leb_first <= 1'b0;
                    end
                    if (take_byte && last_byte) begin
                        state <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    if (instr == INSTR_EXTENDED) begin
                        state <= ST_EXTENDED;
                    end else begin
                        state <= ST_READY;
                    end
                end
                default: begin
                    if (write_status) begin
                        state <= ST_READY;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_this_cycle || write_header || write_status) begin
            row_pending <= 1'b0;
        end else if (emit_row) begin
            row_pending <= 1'b1;
        end
    end

    assign status         = row_pending;
    assign user_interrupt = row_pending;

    assign cmd.exec               = state == ST_EXEC;
    assign cmd.instr              = instr;
    assign cmd.negate_stmt        = take_opcode && current_byte == DW_LNS_NEGATE_STMT;
    assign cmd.set_basic_block    = take_opcode && current_byte == DW_LNS_SET_BASIC_BLOCK;
    assign cmd.set_end_sequence   = take_sub_opcode && current_byte == DW_LNE_END_SEQUENCE;
    assign cmd.clear_row_flags    = write_status && paused;
    assign cmd.end_sequence_reset = write_status && state == ST_PAUSE_END;

endmodule

// ==== hdl/line_state_regs.sv ====
// Abstract machine registers of the line program, updated by commands from the opcode FSM
module line_state_regs
    import line_table_pkg::*;
#(
    parameter int ADDR_W = DEFAULT_ADDR_W,
    parameter int FILE_W = DEFAULT_FILE_W,
    parameter int LINE_W = DEFAULT_LINE_W,
    parameter int COL_W  = DEFAULT_COL_W
) (
    input  logic                 clk,
    input  logic                 reset_this_cycle,
    input  logic                 write_header,
    input  logic                 header_stmt,
    input  logic [OPERAND_W-1:0] operand,
    line_cmd_if.regs             cmd,
    output logic [ADDR_W-1:0]    am_address,
    output logic [FILE_W-1:0]    am_file,
    output logic [LINE_W-1:0]    am_line,
    output logic [COL_W-1:0]     am_column,
    output logic                 am_is_stmt,
    output logic                 am_basic_block,
    output logic                 am_end_sequence,
    output logic                 default_is_stmt
);
    logic                 restart;
    logic [OPERAND_W-1:0] adder_src;
    logic [OPERAND_W-1:0] adder_sum;

    // A new sequence starts after reset, a header write or a resumed end_sequence row
    assign restart = reset_this_cycle || write_header || cmd.end_sequence_reset;

    // advance_pc and advance_line never execute together, so one adder serves both
    assign adder_src = (cmd.instr == INSTR_ADVANCE_PC) ? OPERAND_W'(am_address) :
                       OPERAND_W'(am_line);
    assign adder_sum = adder_src + operand;

    always_ff @(posedge clk) begin
        if (restart) begin
            am_address <= '0;
            am_file    <= FILE_W'(1);
            am_line    <= LINE_W'(1);
            am_column  <= '0;
        end else if (cmd.exec) begin
            case (cmd.instr)
                INSTR_ADVANCE_PC:   am_address <= {adder_sum[ADDR_W-1:1], 1'b0};
                INSTR_ADVANCE_LINE: am_line    <= adder_sum[LINE_W-1:0];
                INSTR_SET_FILE:     am_file    <= operand[FILE_W-1:0];
                INSTR_SET_COLUMN:   am_column  <= operand[COL_W-1:0];
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_this_cycle) begin
            default_is_stmt <= 1'b0;
            am_is_stmt      <= 1'b0;
        end else if (write_header) begin
            default_is_stmt <= header_stmt;
            am_is_stmt      <= header_stmt;
        end else if (cmd.end_sequence_reset) begin
            am_is_stmt <= default_is_stmt;
        end else if (cmd.negate_stmt) begin
            am_is_stmt <= !am_is_stmt;
        end
    end

    // basic_block lasts for one row, end_sequence until the sequence restarts
    always_ff @(posedge clk) begin
        if (reset_this_cycle || write_header || cmd.clear_row_flags) begin
            am_basic_block <= 1'b0;
        end else if (cmd.set_basic_block) begin
            am_basic_block <= 1'b1;
        end
        if (restart) begin
            am_end_sequence <= 1'b0;
        end else if (cmd.set_end_sequence) begin
            am_end_sequence <= 1'b1;
        end
    end

endmodule

// ==== hdl/line_table_accelerator.sv ====
// Top level of the DWARF v5 line table accelerator as seen by the host register bus
module line_table_accelerator
    import line_table_pkg::*;
#(
    parameter int ADDR_W = DEFAULT_ADDR_W,
    parameter int FILE_W = DEFAULT_FILE_W,
    parameter int LINE_W = DEFAULT_LINE_W,
    parameter int COL_W  = DEFAULT_COL_W
) (
    input  logic        clk,
    input  logic        reset_this_cycle,
    input  logic [5:0]  address,
    input  logic [31:0] data_in,
    input  rw_size_e    data_write_n,
    input  rw_size_e    data_read_n,
    output logic [31:0] data_out,
    output logic        data_ready,
    output logic        user_interrupt
);
    logic                 write_header;
    logic                 write_code;
    logic                 write_status;
    logic                 take_byte;
    logic                 byte_valid;
    logic [7:0]           current_byte;
    logic                 start_leb;
    logic                 is_signed;
    logic                 last_byte;
    logic [OPERAND_W-1:0] operand;
    logic                 status;
    logic [ADDR_W-1:0]    am_address;
    logic [FILE_W-1:0]    am_file;
    logic [LINE_W-1:0]    am_line;
    logic [COL_W-1:0]     am_column;
    logic                 am_is_stmt;
    logic                 am_basic_block;
    logic                 am_end_sequence;
    logic                 default_is_stmt;
    logic [31:0]          row_line_col_flags;

    line_cmd_if cmd_if ();

    // Line in bits 15:0, column in 25:16, then is_stmt, basic_block and end_sequence
    assign row_line_col_flags = {3'h0, am_end_sequence, am_basic_block, am_is_stmt,
                                 10'(am_column), 16'(am_line)};

    host_register_port u_host_port (
        .reset_this_cycle  (reset_this_cycle),
        .address           (address),
        .data_write_n      (data_write_n),
        .data_read_n       (data_read_n),
        .row_address       (32'(am_address)),
        .row_file          (32'(am_file)),
        .row_line_col_flags(row_line_col_flags),
        .header_word       ({31'h0, default_is_stmt}),
        .status            (status),
        .data_out          (data_out),
        .data_ready        (data_ready),
        .write_header      (write_header),
        .write_code        (write_code),
        .write_status      (write_status)
    );

    code_buffer u_code_buffer (
        .clk             (clk),
        .reset_this_cycle(reset_this_cycle),
        .write_header    (write_header),
        .write_code      (write_code),
        .write_size      (data_write_n),
        .data_in         (data_in),
        .take_byte       (take_byte),
        .current_byte    (current_byte),
        .byte_valid      (byte_valid)
    );

    operand_decoder #(
        .OPERAND_W(OPERAND_W)
    ) u_operand_decoder (
        .clk             (clk),
        .reset_this_cycle(reset_this_cycle),
        .write_header    (write_header),
        .start_leb       (start_leb),
        .is_signed       (is_signed),
        .take_byte       (take_byte),
        .byte_in         (current_byte),
        .operand         (operand),
        .last_byte       (last_byte)
    );

    line_program_control u_control (
        .clk             (clk),
        .reset_this_cycle(reset_this_cycle),
        .write_header    (write_header),
        .write_status    (write_status),
        .current_byte    (current_byte),
        .byte_valid      (byte_valid),
        .last_byte       (last_byte),
        .take_byte       (take_byte),
        .start_leb       (start_leb),
        .is_signed       (is_signed),
        .cmd             (cmd_if.ctrl),
        .status          (status),
        .user_interrupt  (user_interrupt)
    );

    line_state_regs #(
        .ADDR_W(ADDR_W),
        .FILE_W(FILE_W),
        .LINE_W(LINE_W),
        .COL_W (COL_W)
    ) u_state_regs (
        .clk             (clk),
        .reset_this_cycle(reset_this_cycle),
        .write_header    (write_header),
        .header_stmt     (data_in[0]),
        .operand         (operand),
        .cmd             (cmd_if.regs),
        .am_address      (am_address),
        .am_file         (am_file),
        .am_line         (am_line),
        .am_column       (am_column),
        .am_is_stmt      (am_is_stmt),
        .am_basic_block  (am_basic_block),
        .am_end_sequence (am_end_sequence),
        .default_is_stmt (default_is_stmt)
    );

endmodule

// ==== hdl/line_table_pkg.sv ====
// Register map, host access sizes, DWARF opcodes and widths shared by the line table accelerator
package line_table_pkg;

    // Access size as encoded on data_write_n and data_read_n
    typedef enum logic [1:0] {
        RW_8_BIT  = 2'h0,
        RW_16_BIT = 2'h1,
        RW_32_BIT = 2'h2,
        RW_NONE   = 2'h3
    } rw_size_e;

    typedef enum logic [5:0] {
        PROGRAM_HEADER    = 6'h0,
        PROGRAM_CODE      = 6'h1,
        AM_ADDRESS        = 6'h2,
        AM_FILE           = 6'h3,
        AM_LINE_COL_FLAGS = 6'h4,
        STATUS            = 6'h5
    } reg_addr_e;

    // Standard opcodes handled by the parser, anything else is skipped as a single byte
    localparam logic [7:0] DW_LNS_COPY            = 8'h01;
    localparam logic [7:0] DW_LNS_ADVANCE_PC      = 8'h02;
    localparam logic [7:0] DW_LNS_ADVANCE_LINE    = 8'h03;
    localparam logic [7:0] DW_LNS_SET_FILE        = 8'h04;
    localparam logic [7:0] DW_LNS_SET_COLUMN      = 8'h05;
    localparam logic [7:0] DW_LNS_NEGATE_STMT     = 8'h06;
    localparam logic [7:0] DW_LNS_SET_BASIC_BLOCK = 8'h07;

    localparam logic [7:0] EXT_OPCODE_ESCAPE   = 8'h00;
    localparam logic [7:0] DW_LNE_END_SEQUENCE = 8'h01;

    // Instruction waiting for its LEB128 operand to complete
    typedef enum logic [2:0] {
        INSTR_NOP,
        INSTR_ADVANCE_PC,
        INSTR_ADVANCE_LINE,
        INSTR_SET_FILE,
        INSTR_SET_COLUMN,
        INSTR_EXTENDED
    } instr_e;

    localparam int OPERAND_W = 28;

    localparam int DEFAULT_ADDR_W = 28;
    localparam int DEFAULT_FILE_W = 16;
    localparam int DEFAULT_LINE_W = 16;
    localparam int DEFAULT_COL_W  = 10;

endpackage

// ==== hdl/operand_decoder.sv ====
// Builds LEB128 operands one 7-bit group per taken byte, sign-extending signed operands
module operand_decoder #(
    parameter int OPERAND_W = 28
) (
    input  logic                 clk,
    input  logic                 reset_this_cycle,
    input  logic                 write_header,
    input  logic                 start_leb,
    input  logic                 is_signed,
    input  logic                 take_byte,
    input  logic [7:0]           byte_in,
    output logic [OPERAND_W-1:0] operand,
    output logic                 last_byte
);
    localparam int GROUPS  = (OPERAND_W + 6) / 7;
    localparam int GROUP_W = $clog2(GROUPS + 1);

    logic [GROUP_W-1:0]   group_cnt;
    logic [GROUP_W-1:0]   group_sel;
    logic                 sign_flag;
    logic                 in_leb;
    logic                 leb_take;
    logic                 extend;
    logic [OPERAND_W-1:0] keep_mask;
    logic [OPERAND_W-1:0] placed;
    logic [OPERAND_W-1:0] fill;

    assign last_byte = !byte_in[7];
    assign leb_take  = take_byte && (start_leb || in_leb);
    assign group_sel = start_leb ? '0 : group_cnt;
    assign extend    = (start_leb ? is_signed : sign_flag) && byte_in[6];

    // Groups past the operand width shift out entirely and leave the operand unchanged
    assign keep_mask = ~({OPERAND_W{1'b1}} << (7 * group_sel));
    assign placed    = OPERAND_W'(byte_in[6:0]) << (7 * group_sel);
    assign fill      = extend ? ({OPERAND_W{1'b1}} << (7 * group_sel + 7)) : '0;

    always_ff @(posedge clk) begin
        if (reset_this_cycle || write_header) begin
            in_leb    <= 1'b0;
            group_cnt <= '0;
            sign_flag <= 1'b0;
        end else if (leb_take) begin
            in_leb    <= !last_byte;
            group_cnt <= (group_sel == GROUP_W'(GROUPS)) ? group_sel : group_sel + 1'b1;
            sign_flag <= start_leb ? is_signed : sign_flag;
        end
    end

    always_ff @(posedge clk) begin
        if (leb_take) begin
            operand <= (operand & keep_mask) | placed | fill;
        end
    end

endmodule

// ==== testbench/line_table_props.sv ====
// Concurrent checks on the accelerator ports, bound to line_table_accelerator by the testbench
module line_table_props
    import line_table_pkg::*;
(
    input logic       clk,
    input logic       reset_this_cycle,
    input logic [5:0] address,
    input rw_size_e   data_write_n,
    input logic       data_ready,
    input logic       user_interrupt
);
    int   failures = 0;
    logic status_write;

    assign status_write = data_write_n != RW_NONE && address == STATUS;

    ready_always_high: assert property (@(posedge clk) data_ready)
    else begin
        $error("data_ready went low");
        failures++;
    end

    interrupt_low_after_reset: assert property (@(posedge clk) reset_this_cycle |=> !user_interrupt)
    else begin
        $error("user_interrupt high in the cycle after reset");
        failures++;
    end

    // A STATUS write clears the pending row on the next edge
    interrupt_falls_after_status: assert property (
        @(posedge clk) disable iff (reset_this_cycle) status_write |=> !user_interrupt)
    else begin
        $error("user_interrupt still high after a STATUS write");
        failures++;
    end

endmodule

// ==== testbench/line_table_tb.sv ====
// Table-driven testbench for the line table accelerator, run from verilog.f with line_table_tb as top
module line_table_tb
    import line_table_pkg::*;
();
    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 3;
    localparam int CYCLES_PER_TEST = 64;

    typedef struct {
        logic [5:0]  addr;
        logic [31:0] data;
        rw_size_e    size;
    } bus_write_t;

    // Each row test owns the writes from index first up to the next test's first
    typedef struct {
        string       name;
        int          first;
        logic [31:0] exp_address;
        logic [31:0] exp_file;
        logic [31:0] exp_flags;
    } row_test_t;

    logic        clk;
    logic        reset_this_cycle;
    logic [5:0]  address;
    logic [31:0] data_in;
    rw_size_e    data_write_n;
    rw_size_e    data_read_n;
    logic [31:0] data_out;
    logic        data_ready;
    logic        user_interrupt;

    bus_write_t writes[$];
    row_test_t  tests[$];
    bit         table_ready;

    line_table_accelerator dut0 (
        .clk             (clk),
        .reset_this_cycle(reset_this_cycle),
        .address         (address),
        .data_in         (data_in),
        .data_write_n    (data_write_n),
        .data_read_n     (data_read_n),
        .data_out        (data_out),
        .data_ready      (data_ready),
        .user_interrupt  (user_interrupt)
    );

    bind line_table_accelerator line_table_props props0 (
        .clk             (clk),
        .reset_this_cycle(reset_this_cycle),
        .address         (address),
        .data_write_n    (data_write_n),
        .data_ready      (data_ready),
        .user_interrupt  (user_interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Line in 15:0, column in 25:16, then is_stmt, basic_block and end_sequence
    function automatic logic [31:0] row_word(input int line, input int column, input bit is_stmt,
                                             input bit basic_block, input bit end_sequence);
        return {3'h0, end_sequence, basic_block, is_stmt, column[9:0], line[15:0]};
    endfunction

    function automatic int byte_count(input rw_size_e size);
        case (size)
            RW_8_BIT:  return 1;
            RW_16_BIT: return 2;
            RW_32_BIT: return 4;
            default:   return 0;
        endcase
    endfunction

    function automatic void add_test(input string name, input logic [31:0] exp_address,
                                     input logic [31:0] exp_file, input logic [31:0] exp_flags);
        row_test_t t;
        t.name        = name;
        t.first       = writes.size();
        t.exp_address = exp_address;
        t.exp_file    = exp_file;
        t.exp_flags   = exp_flags;
        tests.push_back(t);
    endfunction

    function automatic void add_write(input logic [5:0] reg_addr, input logic [31:0] value,
                                      input rw_size_e size);
        bus_write_t w;
        w.addr = reg_addr;
        w.data = value;
        w.size = size;
        writes.push_back(w);
    endfunction

    // Code words are little endian, so the first opcode sits in bits 7:0
    function automatic void build_table();
        add_test("row_values", 32'h10, 32'h2, row_word(1 - 3, 5, 1, 0, 0));
        add_write(PROGRAM_HEADER, 32'h1, RW_32_BIT);
        add_write(PROGRAM_CODE, 32'h7D03_1002, RW_32_BIT);
        add_write(PROGRAM_CODE, 32'h0505_0204, RW_32_BIT);
        add_write(PROGRAM_CODE, 32'h01, RW_8_BIT);
        add_test("flags_row", 32'h0, 32'h1, row_word(1, 0, 0, 1, 0));
        add_write(PROGRAM_HEADER, 32'h1, RW_32_BIT);
        add_write(PROGRAM_CODE, 32'h0706, RW_16_BIT);
        add_write(PROGRAM_CODE, 32'h01, RW_8_BIT);
        add_test("flags_next_row", 32'h0, 32'h1, row_word(1, 0, 0, 0, 0));
        add_write(PROGRAM_CODE, 32'h01, RW_8_BIT);
        add_test("end_sequence", 32'h0, 32'h1, row_word(1 + 5, 0, 0, 0, 1));
        add_write(PROGRAM_HEADER, 32'h1, RW_32_BIT);
        add_write(PROGRAM_CODE, 32'h0006_0503, RW_32_BIT);
        add_write(PROGRAM_CODE, 32'h0101, RW_16_BIT);
        add_test("after_end_sequence", 32'h0, 32'h1, row_word(1, 0, 1, 0, 0));
        add_write(PROGRAM_CODE, 32'h01, RW_8_BIT);
        // advance_line 200 as the two-byte LEB128 C8 01
        add_test("leb_split", 32'h0, 32'h1, row_word(1 + 200, 0, 0, 0, 0));
        add_write(PROGRAM_HEADER, 32'h0, RW_32_BIT);
        add_write(PROGRAM_CODE, 32'h03, RW_8_BIT);
        add_write(PROGRAM_CODE, 32'hC8, RW_8_BIT);
        add_write(PROGRAM_CODE, 32'h01, RW_8_BIT);
        add_write(PROGRAM_CODE, 32'h01, RW_8_BIT);
        add_test("leb_unsplit", 32'h0, 32'h1, row_word(1 + 200, 0, 0, 0, 0));
        add_write(PROGRAM_HEADER, 32'h0, RW_32_BIT);
        add_write(PROGRAM_CODE, 32'h0101_C803, RW_32_BIT);
        add_test("header_mid_program", 32'h0, 32'h1, row_word(1, 0, 0, 0, 0));
        add_write(PROGRAM_HEADER, 32'h1, RW_32_BIT);
        add_write(PROGRAM_CODE, 32'h0705_2002, RW_32_BIT);
        add_write(PROGRAM_HEADER, 32'h0, RW_32_BIT);
        add_write(PROGRAM_CODE, 32'h01, RW_8_BIT);
    endfunction

    task automatic host_write(input logic [5:0] reg_addr, input logic [31:0] value,
                              input rw_size_e size);
        @(posedge clk);
        address      <= reg_addr;
        data_in      <= value;
        data_write_n <= size;
        @(posedge clk);
        data_write_n <= RW_NONE;
    endtask

    // Reads are combinational, so data_out is sampled mid-cycle
    task automatic host_read(input logic [5:0] reg_addr, output logic [31:0] value);
        @(posedge clk);
        address     <= reg_addr;
        data_read_n <= RW_32_BIT;
        @(negedge clk);
        value = data_out;
        @(posedge clk);
        data_read_n <= RW_NONE;
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("mismatch %s %s: expected %h, actual %h", test, field, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "register check failed");
        end
    endtask

    task automatic run_test(input int idx);
        int          last;
        logic [31:0] value;
        last = (idx + 1 < tests.size()) ? tests[idx + 1].first : writes.size();
        for (int i = tests[idx].first; i < last; i++) begin
            host_write(writes[i].addr, writes[i].data, writes[i].size);
            // The parser drains a word in at most one take and one exec cycle per byte
            if (i + 1 < last) begin
                repeat (2 * byte_count(writes[i].size) + 1) @(posedge clk);
            end
        end
        @(negedge clk);
        while (user_interrupt !== 1'b1) @(negedge clk);
        host_read(AM_ADDRESS, value);
        check_value(tests[idx].name, "address", tests[idx].exp_address, value);
        host_read(AM_FILE, value);
        check_value(tests[idx].name, "file", tests[idx].exp_file, value);
        host_read(AM_LINE_COL_FLAGS, value);
        check_value(tests[idx].name, "line_col_flags", tests[idx].exp_flags, value);
        host_read(STATUS, value);
        check_value(tests[idx].name, "status", 32'h1, value);
        host_write(STATUS, 32'h0, RW_32_BIT);
    endtask

    initial begin
        logic [31:0] value;
        reset_this_cycle <= 1'b1;
        address          <= '0;
        data_in          <= '0;
        data_write_n     <= RW_NONE;
        data_read_n      <= RW_NONE;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_this_cycle <= 1'b0;

        @(negedge clk);
        check_value("reset", "user_interrupt", 32'h0, 32'(user_interrupt));
        host_read(STATUS, value);
        check_value("reset", "status", 32'h0, value);
        host_read(AM_ADDRESS, value);
        check_value("reset", "address", 32'h0, value);
        host_read(AM_FILE, value);
        check_value("reset", "file", 32'h1, value);
        host_read(AM_LINE_COL_FLAGS, value);
        check_value("reset", "line_col_flags", row_word(1, 0, 0, 0, 0), value);

        for (int t = 0; t < tests.size(); t++) begin
            run_test(t);
        end
        repeat (2) @(posedge clk);

        if (dut0.props0.failures == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", dut0.props0.failures);
            $display("Result: FAILED");
            $fatal(1, "assertion failures");
        end
    end

    // Budget covers reset, the reset checks and every table entry
    initial begin
        wait (table_ready);
        #((RESET_CYCLES + CYCLES_PER_TEST * (tests.size() + 1)) * CLK_PERIOD);
        $display("Run timed out waiting for the DUT to raise user_interrupt");
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== verilog.f ====
hdl/line_table_pkg.sv
hdl/line_cmd_if.sv
hdl/host_register_port.sv
hdl/code_buffer.sv
hdl/operand_decoder.sv
hdl/line_program_control.sv
hdl/line_state_regs.sv
hdl/line_table_accelerator.sv
testbench/line_table_props.sv
testbench/line_table_tb.sv
